//--- hdl/decode_pkg.sv
/*
 * Shared definitions for the decode operand stage
 * Data, instruction and register index types, field positions,
 * read port indices and the operand/immediate select encodings
 */

package decode_pkg;

  ////////////////////////////////////////////////////
  // Widths and sizes
  ////////////////////////////////////////////////////

  localparam int WORD_W         = 32;
  localparam int REG_ADDR_W     = 5;
  localparam int NUM_REGS       = 32;
  localparam int NUM_READ_PORTS = 3;

  // Read port slots in the register file and forward arrays
  localparam int RA_IDX = 0;
  localparam int RB_IDX = 1;
  localparam int RC_IDX = 2;

  // Register field positions in the instruction word
  localparam int RA_LSB = 16;
  localparam int RB_LSB = 11;
  // rc doubles as write address
  localparam int RC_LSB = 21;

  typedef logic [WORD_W-1:0]     word_t;
  typedef logic [31:0]           instr_t;
  typedef logic [REG_ADDR_W-1:0] reg_addr_t;

  ////////////////////////////////////////////////////
  // Operand select encodings
  ////////////////////////////////////////////////////

  // Operand A source
  typedef enum logic [1:0] {
    OP_A_REG   = 2'd0,
    OP_A_PC    = 2'd1,
    OP_A_IMM16 = 2'd2
  } op_a_sel_e;

  // Operand B source
  typedef enum logic [1:0] {
    OP_B_REG  = 2'd0,
    OP_B_REGC = 2'd1,
    OP_B_IMM  = 2'd2
  } op_b_sel_e;

  // Immediate format for operand B
  typedef enum logic [3:0] {
    IMM_16   = 4'd0,
    IMM_5N11 = 4'd1,
    IMM_21S  = 4'd2,
    IMM_8Z   = 4'd3,
    IMM_16Z  = 4'd4,
    IMM_11S  = 4'd5,
    IMM_5N6S = 4'd6,
    IMM_VEC  = 4'd7,
    IMM_FOUR = 4'd8
  } imm_sel_e;

  // SIMD element size
  typedef enum logic [1:0] {
    VEC_MODE32 = 2'd0,
    VEC_MODE16 = 2'd1,
    VEC_MODE8  = 2'd2
  } vec_mode_e;

endpackage

//--- hdl/register_file.sv
/*
 * 32-entry general purpose register file
 * Three combinational read ports, two write ports,
 * execute port wins on a shared write address
 */

`timescale 1ns/1ps

module register_file
  import decode_pkg::*;
(
  input  logic                             clk,
  input  logic                             rst_n,

  // Read ports, slot order ra, rb, rc
  input  reg_addr_t [NUM_READ_PORTS-1:0]   raddr_i,
  output word_t     [NUM_READ_PORTS-1:0]   rdata_o,

  // Writeback port
  input  logic                             wb_we_i,
  input  reg_addr_t                        wb_waddr_i,
  input  word_t                            wb_wdata_i,

  // Execute result port
  input  logic                             ex_we_i,
  input  reg_addr_t                        ex_waddr_i,
  input  word_t                            ex_wdata_i
);

  // Storage array
  word_t regs [NUM_REGS];

  ////////////////////////////////////////////////////
  // Write side
  ////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      for (int i = 0; i < NUM_REGS; i++)
      begin
        regs[i] <= '0;
      end
    end
    else
    begin
      // Writeback first
      if (wb_we_i)
      begin
        regs[wb_waddr_i] <= wb_wdata_i;
      end
      // Execute last, so it overrides on the same address
      if (ex_we_i)
      begin
        regs[ex_waddr_i] <= ex_wdata_i;
      end
    end
  end

  ////////////////////////////////////////////////////
  // Read side
  ////////////////////////////////////////////////////

  // Plain async reads, same-cycle writes come via forwarding
  always_comb
  begin
    for (int p = 0; p < NUM_READ_PORTS; p++)
    begin
      rdata_o[p] = regs[raddr_i[p]];
    end
  end

  // Enabled writes need a clean address
  a_wb_waddr_known: assert property (@(posedge clk) disable iff (!rst_n)
    wb_we_i |-> !$isunknown(wb_waddr_i));

  a_ex_waddr_known: assert property (@(posedge clk) disable iff (!rst_n)
    ex_we_i |-> !$isunknown(ex_waddr_i));

endmodule

//--- hdl/operand_forward.sv
/*
 * Forwarding unit for one register read operand
 * Picks execute result, then writeback data, then register file data
 */

`timescale 1ns/1ps

module operand_forward
  import decode_pkg::*;
(
  input  reg_addr_t raddr_i,
  input  word_t     rf_data_i,
  input  logic      ex_we_i,
  input  reg_addr_t ex_waddr_i,
  input  word_t     ex_wdata_i,
  input  logic      wb_we_i,
  input  reg_addr_t wb_waddr_i,
  input  word_t     wb_wdata_i,
  output word_t     fwd_data_o
);

  // RAW hazard flags per write port
  logic ex_hit;
  logic wb_hit;

  assign ex_hit = ex_we_i && (ex_waddr_i == raddr_i);
  assign wb_hit = wb_we_i && (wb_waddr_i == raddr_i);

  // Newest value wins
  assign fwd_data_o = ex_hit ? ex_wdata_i :
                      wb_hit ? wb_wdata_i :
                               rf_data_i;

  // Known source must give a known operand
  a_fwd_known: assert final (
    $isunknown({ex_hit, wb_hit}) ||
    (ex_hit && $isunknown(ex_wdata_i)) ||
    (!ex_hit && wb_hit && $isunknown(wb_wdata_i)) ||
    (!ex_hit && !wb_hit && $isunknown(rf_data_i)) ||
    !$isunknown(fwd_data_o))
  else $error("forwarded operand has unknown bits from a known source");

endmodule

//--- hdl/operand_select.sv
/*
 * Operand builder for the ALU
 * Immediate extraction, operand A and B muxes,
 * scalar replication of operand B
 */

`timescale 1ns/1ps

module operand_select
  import decode_pkg::*;
(
  input  instr_t                        instr_i,
  input  word_t                         current_pc_i,
  input  word_t [NUM_READ_PORTS-1:0]    fwd_data_i,
  input  op_a_sel_e                     op_a_sel_i,
  input  op_b_sel_e                     op_b_sel_i,
  input  imm_sel_e                      imm_sel_i,
  input  logic                          scalar_repl_i,
  input  vec_mode_e                     vec_mode_i,
  output word_t                         op_a_o,
  output word_t                         op_b_o,
  output word_t                         op_c_o,
  output word_t                         rb_data_o
);

  // Immediate candidates
  word_t imm16;
  word_t imm5n11;
  word_t imm21s;
  word_t imm8z;
  word_t imm16z;
  word_t imm11s;
  word_t imm5n6s;
  word_t imm_vec;

  // Operand B path
  word_t imm_b;
  word_t op_b_raw;
  word_t op_b_vec;

  ////////////////////////////////////////////////////
  // Immediate extraction
  ////////////////////////////////////////////////////

  // Always sign extended
  assign imm16   = {{16{instr_i[15]}}, instr_i[15:0]};
  // Split field, sign from bit 25
  assign imm5n11 = {{16{instr_i[25]}}, instr_i[25:21], instr_i[10:0]};
  // Word offsets
  assign imm21s  = {{9{instr_i[20]}}, instr_i[20:0], 2'b00};
  assign imm8z   = {22'b0, instr_i[7:0], 2'b00};
  assign imm16z  = {14'b0, instr_i[15:0], 2'b00};
  // Short signed forms
  assign imm11s  = {{21{instr_i[15]}}, instr_i[15:5]};
  assign imm5n6s = {{21{instr_i[25]}}, instr_i[25:21], instr_i[10:5]};
  // Vector scalar immediate
  assign imm_vec = {{24{instr_i[15]}}, instr_i[15:8]};

  // Format select for operand B
  always_comb
  begin
    case (imm_sel_i)
      IMM_16:   imm_b = imm16;
      IMM_5N11: imm_b = imm5n11;
      IMM_21S:  imm_b = imm21s;
      IMM_8Z:   imm_b = imm8z;
      IMM_16Z:  imm_b = imm16z;
      IMM_11S:  imm_b = imm11s;
      IMM_5N6S: imm_b = imm5n6s;
      IMM_VEC:  imm_b = imm_vec;
      // IMM_FOUR and anything unused
      default:  imm_b = word_t'(4);
    endcase
  end

  ////////////////////////////////////////////////////
  // Operand A
  ////////////////////////////////////////////////////

  always_comb
  begin
    case (op_a_sel_i)
      OP_A_PC:    op_a_o = current_pc_i;
      OP_A_IMM16: op_a_o = imm16;
      default:    op_a_o = fwd_data_i[RA_IDX];
    endcase
  end

  ////////////////////////////////////////////////////
  // Operand B
  ////////////////////////////////////////////////////

  always_comb
  begin
    case (op_b_sel_i)
      OP_B_REGC: op_b_raw = fwd_data_i[RC_IDX];
      OP_B_IMM:  op_b_raw = imm_b;
      default:   op_b_raw = fwd_data_i[RB_IDX];
    endcase
  end

  // Byte splat for 8-bit lanes, halfword splat otherwise
  assign op_b_vec = (vec_mode_i == VEC_MODE8) ? {4{op_b_raw[7:0]}}
                                              : {2{op_b_raw[15:0]}};

  assign op_b_o = scalar_repl_i ? op_b_vec : op_b_raw;

  // Operand C and store data straight from forwarding
  assign op_c_o    = fwd_data_i[RC_IDX];
  assign rb_data_o = fwd_data_i[RB_IDX];

endmodule

//--- hdl/id_ex_regs.sv
/*
 * ID/EX pipeline register
 * Operands, store data and write address with a one-cycle valid flag
 */

`timescale 1ns/1ps

module id_ex_regs
  import decode_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,

  // From decode
  input  logic      valid_i,
  input  word_t     op_a_i,
  input  word_t     op_b_i,
  input  word_t     op_c_i,
  input  word_t     rb_data_i,
  input  reg_addr_t waddr_i,

  // To execute
  output logic      valid_ex_o,
  output word_t     op_a_ex_o,
  output word_t     op_b_ex_o,
  output word_t     op_c_ex_o,
  output word_t     rb_data_ex_o,
  output reg_addr_t waddr_ex_o
);

  // Valid flag, one cycle per strobe
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      valid_ex_o <= 1'b0;
    end
    else
    begin
      valid_ex_o <= valid_i;
    end
  end

  // Payload, held between strobes
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      op_a_ex_o    <= '0;
      op_b_ex_o    <= '0;
      op_c_ex_o    <= '0;
      rb_data_ex_o <= '0;
      waddr_ex_o   <= '0;
    end
    else if (valid_i)
    begin
      op_a_ex_o    <= op_a_i;
      op_b_ex_o    <= op_b_i;
      op_c_ex_o    <= op_c_i;
      rb_data_ex_o <= rb_data_i;
      waddr_ex_o   <= waddr_i;
    end
  end

  // Back-to-back valid only with back-to-back strobes
  a_valid_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    (valid_ex_o && $past(valid_ex_o)) |-> $past(valid_i));

endmodule

//--- hdl/decode_stage.sv
/*
 * Decode stage operand path, top level
 * Register file, per-operand forwarding, operand builder, ID/EX register
 */

`timescale 1ns/1ps

module decode_stage
  import decode_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,

  // Instruction and its select codes
  input  logic      instr_valid_i,
  input  instr_t    instr_i,
  input  word_t     current_pc_i,
  input  op_a_sel_e op_a_sel_i,
  input  op_b_sel_e op_b_sel_i,
  input  imm_sel_e  imm_sel_i,
  input  logic      scalar_repl_i,
  input  vec_mode_e vec_mode_i,

  // Writeback port
  input  logic      wb_we_i,
  input  reg_addr_t wb_waddr_i,
  input  word_t     wb_wdata_i,

  // Execute result port
  input  logic      ex_we_i,
  input  reg_addr_t ex_waddr_i,
  input  word_t     ex_wdata_i,

  // ID/EX outputs
  output logic      valid_ex_o,
  output word_t     op_a_ex_o,
  output word_t     op_b_ex_o,
  output word_t     op_c_ex_o,
  output word_t     rb_data_ex_o,
  output reg_addr_t waddr_ex_o
);

  reg_addr_t [NUM_READ_PORTS-1:0] rf_raddr;
  word_t     [NUM_READ_PORTS-1:0] rf_rdata;
  word_t     [NUM_READ_PORTS-1:0] fwd_data;

  word_t     op_a;
  word_t     op_b;
  word_t     op_c;
  word_t     rb_data;
  reg_addr_t waddr_id;

  // Register fields of the instruction
  assign rf_raddr[RA_IDX] = instr_i[RA_LSB +: REG_ADDR_W];
  assign rf_raddr[RB_IDX] = instr_i[RB_LSB +: REG_ADDR_W];
  assign rf_raddr[RC_IDX] = instr_i[RC_LSB +: REG_ADDR_W];
  // Destination shares the rc field
  assign waddr_id         = instr_i[RC_LSB +: REG_ADDR_W];

  register_file register_file_inst (
    .clk        ( clk        ),
    .rst_n      ( rst_n      ),
    .raddr_i    ( rf_raddr   ),
    .rdata_o    ( rf_rdata   ),
    .wb_we_i    ( wb_we_i    ),
    .wb_waddr_i ( wb_waddr_i ),
    .wb_wdata_i ( wb_wdata_i ),
    .ex_we_i    ( ex_we_i    ),
    .ex_waddr_i ( ex_waddr_i ),
    .ex_wdata_i ( ex_wdata_i )
  );

  // One forwarding unit per read port
  for (genvar i = 0; i < NUM_READ_PORTS; i++)
  begin : gen_fwd
    operand_forward operand_forward_inst (
      .raddr_i    ( rf_raddr[i] ),
      .rf_data_i  ( rf_rdata[i] ),
      .ex_we_i    ( ex_we_i     ),
      .ex_waddr_i ( ex_waddr_i  ),
      .ex_wdata_i ( ex_wdata_i  ),
      .wb_we_i    ( wb_we_i     ),
      .wb_waddr_i ( wb_waddr_i  ),
      .wb_wdata_i ( wb_wdata_i  ),
      .fwd_data_o ( fwd_data[i] )
    );
  end

  operand_select operand_select_inst (
    .instr_i       ( instr_i       ),
    .current_pc_i  ( current_pc_i  ),
    .fwd_data_i    ( fwd_data      ),
    .op_a_sel_i    ( op_a_sel_i    ),
    .op_b_sel_i    ( op_b_sel_i    ),
    .imm_sel_i     ( imm_sel_i     ),
    .scalar_repl_i ( scalar_repl_i ),
    .vec_mode_i    ( vec_mode_i    ),
    .op_a_o        ( op_a          ),
    .op_b_o        ( op_b          ),
    .op_c_o        ( op_c          ),
    .rb_data_o     ( rb_data       )
  );

  id_ex_regs id_ex_regs_inst (
    .clk          ( clk           ),
    .rst_n        ( rst_n         ),
    .valid_i      ( instr_valid_i ),
    .op_a_i       ( op_a          ),
    .op_b_i       ( op_b          ),
    .op_c_i       ( op_c          ),
    .rb_data_i    ( rb_data       ),
    .waddr_i      ( waddr_id      ),
    .valid_ex_o   ( valid_ex_o    ),
    .op_a_ex_o    ( op_a_ex_o     ),
    .op_b_ex_o    ( op_b_ex_o     ),
    .op_c_ex_o    ( op_c_ex_o     ),
    .rb_data_ex_o ( rb_data_ex_o  ),
    .waddr_ex_o   ( waddr_ex_o    )
  );

endmodule

//--- verification/decode_stage_tb.sv
/*
 * Directed testbench for the decode stage operand path
 * Reference register model, immediate and forwarding models,
 * one check task, cycle-count timeout
 */

`timescale 1ns/1ps

module decode_stage_tb
  import decode_pkg::*;
();

  // Roughly two cycles per strobe plus the write phases
  localparam int TEST_CYCLES    = 300;
  localparam int TIMEOUT_CYCLES = 2 * TEST_CYCLES;

  logic      clk;
  logic      rst_n;
  logic      instr_valid_i;
  instr_t    instr_i;
  word_t     current_pc_i;
  op_a_sel_e op_a_sel_i;
  op_b_sel_e op_b_sel_i;
  imm_sel_e  imm_sel_i;
  logic      scalar_repl_i;
  vec_mode_e vec_mode_i;
  logic      wb_we_i;
  reg_addr_t wb_waddr_i;
  word_t     wb_wdata_i;
  logic      ex_we_i;
  reg_addr_t ex_waddr_i;
  word_t     ex_wdata_i;
  logic      valid_ex_o;
  word_t     op_a_ex_o;
  word_t     op_b_ex_o;
  word_t     op_c_ex_o;
  word_t     rb_data_ex_o;
  reg_addr_t waddr_ex_o;

  // Expected register contents
  word_t  model_regs [NUM_REGS];
  integer seed;
  int     error_count;
  int     cycle_count;

  decode_stage decode_stage_inst (
    .clk           ( clk           ),
    .rst_n         ( rst_n         ),
    .instr_valid_i ( instr_valid_i ),
    .instr_i       ( instr_i       ),
    .current_pc_i  ( current_pc_i  ),
    .op_a_sel_i    ( op_a_sel_i    ),
    .op_b_sel_i    ( op_b_sel_i    ),
    .imm_sel_i     ( imm_sel_i     ),
    .scalar_repl_i ( scalar_repl_i ),
    .vec_mode_i    ( vec_mode_i    ),
    .wb_we_i       ( wb_we_i       ),
    .wb_waddr_i    ( wb_waddr_i    ),
    .wb_wdata_i    ( wb_wdata_i    ),
    .ex_we_i       ( ex_we_i       ),
    .ex_waddr_i    ( ex_waddr_i    ),
    .ex_wdata_i    ( ex_wdata_i    ),
    .valid_ex_o    ( valid_ex_o    ),
    .op_a_ex_o     ( op_a_ex_o     ),
    .op_b_ex_o     ( op_b_ex_o     ),
    .op_c_ex_o     ( op_c_ex_o     ),
    .rb_data_ex_o  ( rb_data_ex_o  ),
    .waddr_ex_o    ( waddr_ex_o    )
  );

  // 8 ns clock
  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Watchdog
  always @(posedge clk)
  begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES)
    begin
      $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Finished with errors");
      $fatal(1, "simulation stopped by the watchdog");
    end
  end

  //////////////////////////////////////////////////
  // Reference models
  //////////////////////////////////////////////////

  function automatic word_t sign_ext(input word_t value, input int width);
    logic signed [31:0] tmp;
    tmp = value << (32 - width);
    return word_t'(tmp >>> (32 - width));
  endfunction

  // Immediate formats as listed in the package
  function automatic word_t expected_imm(input imm_sel_e sel, input instr_t instr);
    case (sel)
      IMM_16:   return sign_ext(word_t'(instr[15:0]), 16);
      IMM_5N11: return sign_ext(word_t'({instr[25:21], instr[10:0]}), 16);
      IMM_21S:  return sign_ext(word_t'(instr[20:0]), 21) << 2;
      IMM_8Z:   return word_t'(instr[7:0]) << 2;
      IMM_16Z:  return word_t'(instr[15:0]) << 2;
      IMM_11S:  return sign_ext(word_t'(instr[15:5]), 11);
      IMM_5N6S: return sign_ext(word_t'({instr[25:21], instr[10:5]}), 11);
      IMM_VEC:  return sign_ext(word_t'(instr[15:8]), 8);
      default:  return 32'd4;
    endcase
  endfunction

  // Execute, then writeback, then stored value
  function automatic word_t forward_value(input reg_addr_t addr);
    if (ex_we_i && ex_waddr_i == addr)
      return ex_wdata_i;
    if (wb_we_i && wb_waddr_i == addr)
      return wb_wdata_i;
    return model_regs[addr];
  endfunction

  function automatic instr_t make_instr(input instr_t filler, input reg_addr_t ra,
                                        input reg_addr_t rb, input reg_addr_t rc);
    instr_t r;
    r        = filler;
    r[20:16] = ra;
    r[15:11] = rb;
    r[25:21] = rc;
    return r;
  endfunction

  //////////////////////////////////////////////////
  // Drive and check helpers
  //////////////////////////////////////////////////

  task automatic check_value(input word_t actual, input word_t expected, input string what);
    if (actual !== expected)
    begin
      error_count++;
      $display("Error at %0t ns: %s is %h, expected %h", $time, what, actual, expected);
      $display("Finished with errors");
      $fatal(1, "stopping at the first mismatch");
    end
  endtask

  // Called right after a rising edge
  task automatic drive_instr(input instr_t instr, input word_t pc, input op_a_sel_e a_sel,
                             input op_b_sel_e b_sel, input imm_sel_e imm_sel,
                             input logic repl, input vec_mode_e vmode);
    instr_valid_i <= 1'b1;
    instr_i       <= instr;
    current_pc_i  <= pc;
    op_a_sel_i    <= a_sel;
    op_b_sel_i    <= b_sel;
    imm_sel_i     <= imm_sel;
    scalar_repl_i <= repl;
    vec_mode_i    <= vmode;
  endtask

  // Capture edge, valid expected in the following cycle
  task automatic capture_result();
    @(posedge clk);
    instr_valid_i <= 1'b0;
    ex_we_i       <= 1'b0;
    wb_we_i       <= 1'b0;
    @(negedge clk);
    check_value(valid_ex_o, 1, "valid in the cycle after the strobe");
  endtask

  task automatic issue_instr(input instr_t instr, input word_t pc, input op_a_sel_e a_sel,
                             input op_b_sel_e b_sel, input imm_sel_e imm_sel,
                             input logic repl, input vec_mode_e vmode);
    @(posedge clk);
    drive_instr(instr, pc, a_sel, b_sel, imm_sel, repl, vmode);
    capture_result();
  endtask

  // Sets the write ports for one edge and mirrors the result in the model
  task automatic write_regs(input logic ex_we, input reg_addr_t ex_a, input word_t ex_d,
                            input logic wb_we, input reg_addr_t wb_a, input word_t wb_d);
    @(posedge clk);
    ex_we_i    <= ex_we;
    ex_waddr_i <= ex_a;
    ex_wdata_i <= ex_d;
    wb_we_i    <= wb_we;
    wb_waddr_i <= wb_a;
    wb_wdata_i <= wb_d;
    // Writeback first so execute overrides
    if (wb_we)
      model_regs[wb_a] = wb_d;
    if (ex_we)
      model_regs[ex_a] = ex_d;
  endtask

  task automatic check_regs_path(input instr_t instr);
    check_value(op_a_ex_o, model_regs[instr[20:16]], "op_a from ra");
    check_value(rb_data_ex_o, model_regs[instr[15:11]], "rb store data");
    check_value(op_c_ex_o, model_regs[instr[25:21]], "op_c from rc");
  endtask

  //////////////////////////////////////////////////
  // Directed tests
  //////////////////////////////////////////////////

  task automatic test_reset_and_strobe();
    instr_t instr;
    @(negedge clk);
    check_value(valid_ex_o, 0, "valid after reset");
    check_value(op_a_ex_o, 0, "op_a after reset");
    check_value(op_b_ex_o, 0, "op_b after reset");
    check_value(op_c_ex_o, 0, "op_c after reset");
    check_value(rb_data_ex_o, 0, "rb data after reset");
    check_value(waddr_ex_o, 0, "waddr after reset");
    for (int i = 0; i < 6; i++)
    begin
      instr = $random(seed);
      issue_instr(instr, 0, OP_A_REG, OP_B_REG, IMM_16, 1'b0, VEC_MODE32);
      check_value(waddr_ex_o, instr[25:21], "waddr from rc field");
      // One-cycle pulse, payload held
      @(negedge clk);
      check_value(valid_ex_o, 0, "valid one cycle after capture");
      check_value(waddr_ex_o, instr[25:21], "waddr held");
    end
  endtask

  task automatic test_register_path();
    instr_t instr;
    reg_addr_t addr;
    for (int i = 0; i < NUM_REGS; i++)
    begin
      addr = $random(seed);
      // Every fourth cycle both ports hit one address
      write_regs(1'b1, reg_addr_t'(i), $random(seed), 1'b1,
                 (i % 4 == 0) ? reg_addr_t'(i) : addr, $random(seed));
    end
    @(posedge clk);
    ex_we_i <= 1'b0;
    wb_we_i <= 1'b0;
    for (int i = 0; i < 16; i++)
    begin
      instr = $random(seed);
      issue_instr(instr, 0, OP_A_REG, OP_B_REG, IMM_16, 1'b0, VEC_MODE32);
      check_regs_path(instr);
      check_value(op_b_ex_o, model_regs[instr[15:11]], "op_b from rb");
    end
  endtask

  task automatic forward_case(input logic ex_we, input reg_addr_t ex_a, input logic wb_we,
                              input reg_addr_t wb_a, input reg_addr_t other);
    instr_t instr;
    word_t  exp_a;
    word_t  exp_c;
    instr = make_instr($random(seed), ex_we ? ex_a : wb_a, ex_we ? ex_a : wb_a, other);
    @(posedge clk);
    drive_instr(instr, 0, OP_A_REG, OP_B_REG, IMM_16, 1'b0, VEC_MODE32);
    write_now(ex_we, ex_a, wb_we, wb_a);
    #1;
    exp_a = forward_value(instr[20:16]);
    exp_c = forward_value(instr[25:21]);
    if (wb_we)
      model_regs[wb_a] = wb_wdata_i;
    if (ex_we)
      model_regs[ex_a] = ex_wdata_i;
    capture_result();
    check_value(op_a_ex_o, exp_a, "forwarded op_a");
    check_value(rb_data_ex_o, exp_a, "forwarded rb data");
    check_value(op_c_ex_o, exp_c, "forwarded op_c");
  endtask

  // Write ports in the strobe cycle
  task automatic write_now(input logic ex_we, input reg_addr_t ex_a, input logic wb_we,
                           input reg_addr_t wb_a);
    ex_we_i    <= ex_we;
    ex_waddr_i <= ex_a;
    ex_wdata_i <= $random(seed);
    wb_we_i    <= wb_we;
    wb_waddr_i <= wb_a;
    wb_wdata_i <= $random(seed);
  endtask

  task automatic test_forwarding();
    forward_case(1'b1, 5'd7, 1'b0, 5'd0, 5'd9);
    forward_case(1'b0, 5'd0, 1'b1, 5'd12, 5'd3);
    forward_case(1'b1, 5'd20, 1'b1, 5'd20, 5'd20);
    // rc hits writeback, ra and rb hit execute
    forward_case(1'b1, 5'd4, 1'b1, 5'd30, 5'd30);
  endtask

  task automatic test_immediates();
    instr_t   instr;
    word_t    pc;
    imm_sel_e sel;
    for (int k = 0; k <= IMM_FOUR; k++)
    begin
      sel = imm_sel_e'(k);
      for (int i = 0; i < 4; i++)
      begin
        instr = $random(seed);
        pc    = $random(seed);
        if (i % 2 == 0)
        begin
          issue_instr(instr, pc, OP_A_IMM16, OP_B_IMM, sel, 1'b0, VEC_MODE32);
          check_value(op_a_ex_o, expected_imm(IMM_16, instr), "op_a imm16");
        end
        else
        begin
          issue_instr(instr, pc, OP_A_PC, OP_B_IMM, sel, 1'b0, VEC_MODE32);
          check_value(op_a_ex_o, pc, "op_a pc");
        end
        check_value(op_b_ex_o, expected_imm(sel, instr), $sformatf("op_b imm %s", sel.name()));
      end
    end
  endtask

  task automatic test_op_b_sources();
    instr_t instr;
    word_t  rb_val;
    for (int i = 0; i < 3; i++)
    begin
      instr = $random(seed);
      issue_instr(instr, 0, OP_A_REG, OP_B_REGC, IMM_16, 1'b0, VEC_MODE32);
      check_value(op_b_ex_o, model_regs[instr[25:21]], "op_b from rc");
      instr  = $random(seed);
      rb_val = model_regs[instr[15:11]];
      issue_instr(instr, 0, OP_A_REG, OP_B_REG, IMM_16, 1'b1, VEC_MODE8);
      check_value(op_b_ex_o, rb_val[7:0] * 32'h0101_0101, "byte replication");
      issue_instr(instr, 0, OP_A_REG, OP_B_REG, IMM_16, 1'b1, VEC_MODE16);
      check_value(op_b_ex_o, rb_val[15:0] * 32'h0001_0001, "halfword replication");
      issue_instr(instr, 0, OP_A_REG, OP_B_IMM, IMM_VEC, 1'b1, VEC_MODE8);
      check_value(op_b_ex_o, (expected_imm(IMM_VEC, instr) & 32'hff) * 32'h0101_0101,
                  "vector imm byte replication");
    end
  endtask

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////

  initial
  begin
    seed          = 56;
    error_count   = 0;
    cycle_count   = 0;
    rst_n         = 1'b0;
    instr_valid_i = 1'b0;
    instr_i       = '0;
    current_pc_i  = '0;
    op_a_sel_i    = OP_A_REG;
    op_b_sel_i    = OP_B_REG;
    imm_sel_i     = IMM_16;
    scalar_repl_i = 1'b0;
    vec_mode_i    = VEC_MODE32;
    wb_we_i       = 1'b0;
    wb_waddr_i    = '0;
    wb_wdata_i    = '0;
    ex_we_i       = 1'b0;
    ex_waddr_i    = '0;
    ex_wdata_i    = '0;
    for (int i = 0; i < NUM_REGS; i++)
      model_regs[i] = '0;

    repeat (4) @(posedge clk);
    rst_n <= 1'b1;

    test_reset_and_strobe();
    test_register_path();
    test_forwarding();
    test_immediates();
    test_op_b_sources();

    if (error_count == 0)
    begin
      $display("Finished with no errors");
      $finish;
    end
    else
    begin
      $display("Finished with errors");
      $fatal(1, "errors were reported");
    end
  end

endmodule

//--- decode_stage.f
hdl/decode_pkg.sv
hdl/register_file.sv
hdl/operand_forward.sv
hdl/operand_select.sv
hdl/id_ex_regs.sv
hdl/decode_stage.sv
verification/decode_stage_tb.sv

//--- Bender.yml
package:
  name: decode_stage

sources:
  - hdl/decode_pkg.sv
  - hdl/register_file.sv
  - hdl/operand_forward.sv
  - hdl/operand_select.sv
  - hdl/id_ex_regs.sv
  - hdl/decode_stage.sv
  - target: simulation
    files:
      - verification/decode_stage_tb.sv
